// ==== build.f ====
+incdir+logic
logic/corePkg.sv
logic/instrDecoder.sv
logic/decodeExecuteReg.sv
logic/executeUnit.sv
logic/decodeExecuteTop.sv
testbench/decodeExecuteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -f build.f --top-module decodeExecuteTb \
	--Mdir obj_dir -o simDecodeExecute > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simDecodeExecute > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$SIM_LOG"; then
	exit 0
fi
exit 1

// ==== testbench/decodeExecuteTb.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module decodeExecuteTb;

	localparam logic [6:0] OpcOpImm  = 7'b0010011;
	localparam logic [6:0] OpcLui    = 7'b0110111;
	localparam logic [6:0] OpcAuipc  = 7'b0010111;
	localparam logic [6:0] OpcJalr   = 7'b1100111;
	localparam logic [6:0] OpcLoad   = 7'b0000011;

	logic               clk;
	logic               arstN;
	logic               flushE;
	corePkg::instrU     instr;
	logic [`XLEN-1:0]   pc;
	logic [`XLEN-1:0]   rs1Val;
	logic [`XLEN-1:0]   rs2Val;
	corePkg::execResult execOut;
	int                 errCount;

	decodeExecuteTop dut (
		.clk     (clk),
		.arstN   (arstN),
		.flushE  (flushE),
		.instr   (instr),
		.pc      (pc),
		.rs1Val  (rs1Val),
		.rs2Val  (rs2Val),
		.execOut (execOut)
	);

	// ******************************
	// Clock and reset
	// ******************************

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (4) @(posedge clk);
		#2 arstN = 1'b1; // Released in the drive slot after edge 4
	end

	// ******************************
	// Instruction encoders
	// ******************************

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd);
		return {f7, 5'd7, 5'd6, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		return {imm, 5'd6, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3);
		return {imm[11:5], 5'd7, 5'd6, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd7, 5'd6, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [`XLEN-1:0] randPc();
		return $urandom() & 32'hffff_fffc;
	endfunction

	// ******************************
	// Reference model
	// ******************************

	function automatic logic [`XLEN-1:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		case (f3)
			3'b000:  return alt ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b011:  return (x < y) ? 32'd1 : 32'd0;
			3'b100:  return x ^ y;
			3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic corePkg::execResult expResult(input logic [31:0] w,
		input logic [`XLEN-1:0] pcV, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		corePkg::execResult r;
		logic [`XLEN-1:0]   immI;
		logic [`XLEN-1:0]   immS;
		logic [`XLEN-1:0]   immB;
		logic [`XLEN-1:0]   immU;
		logic [`XLEN-1:0]   immJ;
		logic [`XLEN-1:0]   alu;
		logic               take;
		r    = '0;
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immU = {w[31:12], 12'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		take = 1'b0;
		case (w[6:0])
			7'b0110011: alu = aluRef(w[14:12], w[30], a, b);
			7'b0010011: alu = aluRef(w[14:12], (w[14:12] == 3'b101) && w[30], a, immI);
			7'b0110111: alu = immU;
			7'b0010111: alu = pcV + immU;
			7'b1101111: alu = pcV + immJ;
			7'b1100111: alu = a + immI;
			7'b1100011: alu = pcV + immB;
			7'b0000011: alu = a + immI;
			7'b0100011: alu = a + immS;
			default:    return '0; // Unsupported opcode is a bubble
		endcase
		case (w[14:12])
			3'b000:  take = a == b;
			3'b001:  take = a != b;
			3'b100:  take = $signed(a) < $signed(b);
			3'b101:  take = !($signed(a) < $signed(b));
			3'b110:  take = a < b;
			3'b111:  take = !(a < b);
			default: take = 1'b0;
		endcase
		r.memAddr   = alu;
		r.writeData = alu;
		r.storeData = b;
		r.target    = alu;
		r.regWrite  = (w[6:0] != 7'b1100011) && (w[6:0] != 7'b0100011);
		r.rd        = r.regWrite ? w[11:7] : 5'd0;
		r.memRead   = w[6:0] == 7'b0000011;
		r.memWrite  = w[6:0] == 7'b0100011;
		if (w[6:0] == 7'b1101111 || w[6:0] == 7'b1100111) begin
			r.writeData = pcV + 32'd4; // Link value
			r.redirect  = 1'b1;
			if (w[6:0] == 7'b1100111) r.target = {alu[`XLEN-1:1], 1'b0};
		end
		if (w[6:0] == 7'b1100011) r.redirect = take;
		return r;
	endfunction

	// ******************************
	// Compare tasks
	// ******************************

	task automatic compareField(input string field, input logic [`XLEN-1:0] act,
		input logic [`XLEN-1:0] expV);
		if (act !== expV) begin
			errCount++;
			$display("FAIL t=%0t execOut.%s got %h expected %h (instr %h)", $time, field, act,
				expV, instr);
		end
	endtask

	task automatic checkResult(input corePkg::execResult act, input corePkg::execResult expV);
		compareField("writeData", act.writeData, expV.writeData);
		compareField("memAddr", act.memAddr, expV.memAddr);
		compareField("storeData", act.storeData, expV.storeData);
		compareField("rd", 32'(act.rd), 32'(expV.rd));
		compareField("regWrite", 32'(act.regWrite), 32'(expV.regWrite));
		compareField("memRead", 32'(act.memRead), 32'(expV.memRead));
		compareField("memWrite", 32'(act.memWrite), 32'(expV.memWrite));
		compareField("redirect", 32'(act.redirect), 32'(expV.redirect));
		if (expV.redirect) compareField("target", act.target, expV.target);
	endtask

	task automatic checkBubble(input corePkg::execResult act);
		compareField("regWrite", 32'(act.regWrite), 32'd0);
		compareField("memRead", 32'(act.memRead), 32'd0);
		compareField("memWrite", 32'(act.memWrite), 32'd0);
		compareField("redirect", 32'(act.redirect), 32'd0);
	endtask

	// ******************************
	// Directed tests
	// ******************************

	// Starts and ends in the drive slot
	task automatic runInstr(input logic [31:0] w, input logic [`XLEN-1:0] pcV,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		corePkg::execResult expV;
		expV   = expResult(w, pcV, a, b);
		instr  = corePkg::instrU'(w);
		pc     = pcV;
		rs1Val = a;
		rs2Val = b;
		@(posedge clk);
		#1;
		checkResult(execOut, expV);
		#1;
	endtask

	task automatic testRType();
		logic [2:0] f3;
		logic [6:0] f7;
		for (int i = 0; i < 10; i++) begin
			f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'b000 : 3'b101); // Last two are sub and sra
			f7 = (i < 8) ? 7'h00 : 7'h20;
			for (int j = 0; j < 4; j++) begin
				runInstr(encR(f7, f3, 5'($urandom_range(31, 1))), randPc(), $urandom(),
					$urandom());
			end
		end
	endtask

	task automatic testIType();
		runInstr(encI(12'hfff, 3'b000, 5'd3, OpcOpImm), randPc(), 32'h0000_0010, 32'd0);
		runInstr(encI(12'h800, 3'b000, 5'd3, OpcOpImm), randPc(), 32'h1234_5678, 32'd0);
		runInstr(encI(12'h7ff, 3'b000, 5'd4, OpcOpImm), randPc(), 32'hffff_ffff, 32'd0);
		runInstr(encI(12'h7ff, 3'b010, 5'd5, OpcOpImm), randPc(), 32'h0000_07ff, 32'd0);
		runInstr(encI(12'h7ff, 3'b010, 5'd5, OpcOpImm), randPc(), 32'h0000_07fe, 32'd0);
		runInstr(encI(12'hfff, 3'b010, 5'd5, OpcOpImm), randPc(), 32'h8000_0000, 32'd0);
		runInstr(encI(12'hfff, 3'b010, 5'd5, OpcOpImm), randPc(), 32'hffff_ffff, 32'd0);
		runInstr(encI(12'hfff, 3'b011, 5'd6, OpcOpImm), randPc(), 32'hffff_fffe, 32'd0);
		runInstr(encI(12'h001, 3'b011, 5'd6, OpcOpImm), randPc(), 32'h0000_0000, 32'd0);
		runInstr(encI(12'h001, 3'b011, 5'd6, OpcOpImm), randPc(), 32'h0000_0001, 32'd0);
		runInstr(encI(12'h01f, 3'b001, 5'd7, OpcOpImm), randPc(), $urandom(), 32'd0);
		runInstr(encI(12'h01f, 3'b101, 5'd7, OpcOpImm), randPc(), 32'h8000_0000, 32'd0);
		runInstr(encI(12'h41f, 3'b101, 5'd7, OpcOpImm), randPc(), 32'h8000_0000, 32'd0);
		runInstr(encI(12'h400, 3'b101, 5'd7, OpcOpImm), randPc(), 32'h8765_4321, 32'd0);
		for (int i = 0; i < 6; i++) begin
			runInstr(encI(12'($urandom()), 3'(4 + i % 3), 5'd8, OpcOpImm), randPc(), $urandom(),
				32'd0); // xori ori andi
		end
	endtask

	task automatic testUpperJump();
		runInstr(encI(12'($urandom()), 3'($urandom()), 5'd9, OpcLui), randPc(), $urandom(),
			32'd0);
		runInstr(encI(12'($urandom()), 3'($urandom()), 5'd9, OpcAuipc), randPc(), $urandom(),
			32'd0);
		runInstr(encJ(21'h000800, 5'd1), randPc(), 32'd0, 32'd0);
		runInstr(encJ(21'h1ffff0, 5'd1), randPc(), 32'd0, 32'd0);
		runInstr(encI(12'h004, 3'b000, 5'd1, OpcJalr), randPc(), 32'h0000_1001, 32'd0);
		runInstr(encI(12'hfff, 3'b000, 5'd2, OpcJalr), randPc(), 32'h0000_2000, 32'd0);
	endtask

	task automatic testBranches();
		logic [`XLEN-1:0] aList [4];
		logic [`XLEN-1:0] bList [4];
		logic [2:0]       code;
		aList = '{32'd5, 32'hffff_fffd, 32'd2, 32'd9}; // Equal, signed less, signed greater
		bList = '{32'd5, 32'd2, 32'hffff_fffd, 32'd4};
		for (int i = 0; i < 6; i++) begin
			code = (i < 2) ? 3'(i) : 3'(i + 2); // beq bne blt bge bltu bgeu
			for (int j = 0; j < 4; j++) begin
				runInstr(encB(j[0] ? 13'h1ff0 : 13'h0008, code), randPc(), aList[j], bList[j]);
			end
		end
	endtask

	task automatic testLoadStore();
		for (int i = 0; i < 4; i++) begin
			runInstr(encI(12'($urandom()), 3'(i), 5'd10, OpcLoad), randPc(), $urandom(),
				$urandom());
			runInstr(encS(12'($urandom()), 3'(i % 3)), randPc(), $urandom(), $urandom());
		end
	endtask

	task automatic testBubbles();
		instr  = corePkg::instrU'(encJ(21'h000100, 5'd1));
		pc     = randPc();
		flushE = 1'b1; // Squash the JAL
		@(posedge clk);
		#1;
		checkBubble(execOut);
		#1;
		flushE = 1'b0;
		runInstr(encI(12'h123, 3'b000, 5'd11, OpcOpImm), randPc(), $urandom(), 32'd0);
		instr = corePkg::instrU'(32'hffff_ffff);
		@(posedge clk);
		#1;
		checkBubble(execOut);
		#1;
	endtask

	task automatic waitResetRelease(output bit ok);
		int cycles;
		cycles = 0;
		while (arstN !== 1'b1 && cycles < 10) begin
			@(negedge clk);
			cycles++;
		end
		ok = (arstN === 1'b1);
		if (!ok) $display("ERROR: reset was not released within %0d cycles", cycles);
	endtask

	// ******************************
	// Test sequence
	// ******************************

	initial begin
		bit ok;
		errCount = 0;
		flushE   = 1'b0;
		instr    = '0;
		pc       = '0;
		rs1Val   = '0;
		rs2Val   = '0;
		void'($urandom(32'hc3f8_0f42));
		@(posedge clk);
		#2;
		instr = corePkg::instrU'(encJ(21'h000040, 5'd1)); // JAL held in reset
		@(posedge clk);
		#1;
		checkBubble(execOut);
		waitResetRelease(ok);
		if (!ok) begin
			errCount++;
		end else begin
			checkBubble(execOut);
			@(posedge clk);
			#2;
			testRType();
			testIType();
			testUpperJump();
			testBranches();
			testLoadStore();
			testBubbles();
		end
		$display("Errors: %0d", errCount);
		if (errCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/decodeExecuteTop.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module decodeExecuteTop (
	input  logic               clk,
	input  logic               arstN,
	input  logic               flushE,
	input  corePkg::instrU     instr,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   rs1Val,
	input  logic [`XLEN-1:0]   rs2Val,
	output corePkg::execResult execOut
);

	corePkg::decodeBundle bundleD; // Decode stage
	corePkg::decodeBundle bundleE; // Execute stage

	instrDecoder uDecoder (
		.instr   (instr),
		.pc      (pc),
		.rs1Val  (rs1Val),
		.rs2Val  (rs2Val),
		.bundleD (bundleD)
	);

	decodeExecuteReg uDeReg (
		.clk     (clk),
		.arstN   (arstN),
		.flushE  (flushE),
		.bundleD (bundleD),
		.bundleE (bundleE)
	);

	executeUnit uExecute (
		.bundleE (bundleE),
		.execOut (execOut)
	);

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module executeUnit (
	input  corePkg::decodeBundle bundleE,
	output corePkg::execResult   execOut
);

	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] aluRes;
	logic [4:0]       shamt;
	logic             taken;

	// ******************************
	// Operand select and ALU
	// ******************************

	always_comb begin
		case (bundleE.opA)
			corePkg::FromPc:   srcA = bundleE.pc;
			corePkg::FromZero: srcA = '0;
			default:           srcA = bundleE.rs1Val;
		endcase
	end

	assign srcB  = (bundleE.opB == corePkg::FromImm) ? bundleE.imm : bundleE.rs2Val;
	assign shamt = srcB[4:0];

	always_comb begin
		case (bundleE.aluCtl)
			corePkg::Add:   aluRes = srcA + srcB;
			corePkg::Sub:   aluRes = srcA - srcB;
			corePkg::Sll:   aluRes = srcA << shamt;
			corePkg::Slt:   aluRes = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			corePkg::Sltu:  aluRes = {{(`XLEN-1){1'b0}}, srcA < srcB};
			corePkg::Xor:   aluRes = srcA ^ srcB;
			corePkg::Srl:   aluRes = srcA >> shamt;
			corePkg::Sra:   aluRes = $signed(srcA) >>> shamt;
			corePkg::Or:    aluRes = srcA | srcB;
			corePkg::And:   aluRes = srcA & srcB;
			corePkg::PassB: aluRes = srcB;
			default:        aluRes = '0;
		endcase
	end

	// ******************************
	// Branch compare and redirect
	// ******************************

	always_comb begin
		case (bundleE.funct3)
			3'b000:  taken = bundleE.rs1Val == bundleE.rs2Val;
			3'b001:  taken = bundleE.rs1Val != bundleE.rs2Val;
			3'b100:  taken = $signed(bundleE.rs1Val) < $signed(bundleE.rs2Val);
			3'b101:  taken = $signed(bundleE.rs1Val) >= $signed(bundleE.rs2Val);
			3'b110:  taken = bundleE.rs1Val < bundleE.rs2Val;
			3'b111:  taken = bundleE.rs1Val >= bundleE.rs2Val;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (bundleE.pcKind)
			corePkg::PcBranch: execOut.redirect = taken;
			corePkg::PcJal:    execOut.redirect = 1'b1;
			corePkg::PcJalr:   execOut.redirect = 1'b1;
			default:           execOut.redirect = 1'b0;
		endcase
	end

	// ALU holds pc+imm or rs1+imm for every control transfer
	assign execOut.target = (bundleE.pcKind == corePkg::PcJalr) ? {aluRes[`XLEN-1:1], 1'b0} :
		aluRes;

	// ******************************
	// Write-back and memory
	// ******************************

	assign execOut.writeData = (bundleE.wb == corePkg::WbPcPlus4) ? bundleE.pcPlus4 : aluRes;
	assign execOut.memAddr   = aluRes;
	assign execOut.storeData = bundleE.rs2Val;
	assign execOut.rd        = bundleE.rd;
	assign execOut.regWrite  = bundleE.regWrite;
	assign execOut.memRead   = bundleE.memRead;
	assign execOut.memWrite  = bundleE.memWrite;

endmodule

// ==== logic/decodeExecuteReg.sv ====
`timescale 1ns/10ps

module decodeExecuteReg (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 flushE,
	input  corePkg::decodeBundle bundleD,
	output corePkg::decodeBundle bundleE
);

	// ******************************
	// Decode to execute register
	// ******************************

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bundleE <= '0; // Bubble while in reset
		end else if (flushE) begin
			bundleE <= '0; // Flush squashes the entry
		end else begin
			bundleE <= bundleD;
		end
	end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module instrDecoder (
	input  corePkg::instrU       instr,
	input  logic [`XLEN-1:0]     pc,
	input  logic [`XLEN-1:0]     rs1Val,
	input  logic [`XLEN-1:0]     rs2Val,
	output corePkg::decodeBundle bundleD
);

	localparam logic [6:0] OpcOp     = 7'b0110011;
	localparam logic [6:0] OpcOpImm  = 7'b0010011;
	localparam logic [6:0] OpcLui    = 7'b0110111;
	localparam logic [6:0] OpcAuipc  = 7'b0010111;
	localparam logic [6:0] OpcJal    = 7'b1101111;
	localparam logic [6:0] OpcJalr   = 7'b1100111;
	localparam logic [6:0] OpcBranch = 7'b1100011;
	localparam logic [6:0] OpcLoad   = 7'b0000011;
	localparam logic [6:0] OpcStore  = 7'b0100011;

	// Bit 30 selects sub and sra, only for register ops when funct3 is 000
	function automatic corePkg::aluOp aluFromFunct(input logic [2:0] f3, input logic alt,
		input logic isReg);
		case (f3)
			3'b000:  return (alt && isReg) ? corePkg::Sub : corePkg::Add;
			3'b001:  return corePkg::Sll;
			3'b010:  return corePkg::Slt;
			3'b011:  return corePkg::Sltu;
			3'b100:  return corePkg::Xor;
			3'b101:  return alt ? corePkg::Sra : corePkg::Srl;
			3'b110:  return corePkg::Or;
			default: return corePkg::And;
		endcase
	endfunction

	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;
	logic             legal;

	// ******************************
	// Immediate assembly
	// ******************************

	assign immI = {{(`XLEN-12){instr.iFmt.imm11to0[11]}}, instr.iFmt.imm11to0};
	assign immS = {{(`XLEN-12){instr.sFmt.imm11to5[6]}}, instr.sFmt.imm11to5,
		instr.sFmt.imm4to0};
	assign immB = {{(`XLEN-12){instr.bFmt.imm12}}, instr.bFmt.imm11, instr.bFmt.imm10to5,
		instr.bFmt.imm4to1, 1'b0};
	assign immU = {instr.uFmt.imm31to12, 12'b0};
	assign immJ = {{(`XLEN-20){instr.jFmt.imm20}}, instr.jFmt.imm19to12, instr.jFmt.imm11,
		instr.jFmt.imm10to1, 1'b0};

	// ******************************
	// Control decode
	// ******************************

	always_comb begin
		bundleD = '0;
		legal   = 1'b1;
		case (instr.rFmt.opcode)
			OpcOp: begin
				bundleD.aluCtl   = aluFromFunct(instr.rFmt.funct3, instr.rFmt.funct7[5], 1'b1);
				bundleD.rs1Addr  = instr.rFmt.rs1;
				bundleD.rs2Addr  = instr.rFmt.rs2;
				bundleD.rd       = instr.rFmt.rd;
				bundleD.regWrite = 1'b1;
			end
			OpcOpImm: begin
				bundleD.aluCtl   = aluFromFunct(instr.iFmt.funct3, instr.iFmt.imm11to0[10], 1'b0);
				bundleD.opB      = corePkg::FromImm;
				bundleD.imm      = immI; // Low five bits are the shift amount
				bundleD.rs1Addr  = instr.iFmt.rs1;
				bundleD.rd       = instr.iFmt.rd;
				bundleD.regWrite = 1'b1;
			end
			OpcLui, OpcAuipc: begin
				bundleD.aluCtl   = instr.uFmt.opcode[5] ? corePkg::PassB : corePkg::Add;
				bundleD.opA      = instr.uFmt.opcode[5] ? corePkg::FromZero : corePkg::FromPc;
				bundleD.opB      = corePkg::FromImm;
				bundleD.imm      = immU;
				bundleD.rd       = instr.uFmt.rd;
				bundleD.regWrite = 1'b1;
			end
			OpcJal, OpcJalr: begin
				bundleD.opB      = corePkg::FromImm; // ALU forms the target
				bundleD.wb       = corePkg::WbPcPlus4;
				bundleD.rd       = instr.jFmt.rd;
				bundleD.regWrite = 1'b1;
				if (instr.jFmt.opcode[3]) begin
					bundleD.opA    = corePkg::FromPc;
					bundleD.imm    = immJ;
					bundleD.pcKind = corePkg::PcJal;
				end else begin
					bundleD.imm     = immI;
					bundleD.rs1Addr = instr.iFmt.rs1;
					bundleD.pcKind  = corePkg::PcJalr;
				end
			end
			OpcBranch: begin
				bundleD.opA     = corePkg::FromPc;
				bundleD.opB     = corePkg::FromImm;
				bundleD.imm     = immB;
				bundleD.rs1Addr = instr.bFmt.rs1;
				bundleD.rs2Addr = instr.bFmt.rs2;
				bundleD.pcKind  = corePkg::PcBranch;
			end
			OpcLoad: begin
				bundleD.opB      = corePkg::FromImm;
				bundleD.imm      = immI;
				bundleD.wb       = corePkg::WbMem;
				bundleD.rs1Addr  = instr.iFmt.rs1;
				bundleD.rd       = instr.iFmt.rd;
				bundleD.regWrite = 1'b1;
				bundleD.memRead  = 1'b1;
			end
			OpcStore: begin
				bundleD.opB      = corePkg::FromImm;
				bundleD.imm      = immS;
				bundleD.rs1Addr  = instr.sFmt.rs1;
				bundleD.rs2Addr  = instr.sFmt.rs2;
				bundleD.memWrite = 1'b1;
			end
			default: legal = 1'b0; // Unknown opcode stays a bubble
		endcase
		if (legal) begin
			bundleD.pc      = pc;
			bundleD.pcPlus4 = pc + `XLEN'd4;
			bundleD.rs1Val  = rs1Val;
			bundleD.rs2Val  = rs2Val;
			bundleD.funct3  = instr.rFmt.funct3;
		end
	end

endmodule

// ==== logic/corePkg.sv ====
`include "core_settings.svh"

package corePkg;

	// ******************************
	// Instruction formats
	// ******************************

	typedef struct packed {
		logic [6:0]             funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} rFmtS;

	typedef struct packed {
		logic [11:0]            imm11to0;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} iFmtS;

	typedef struct packed {
		logic [6:0]             imm11to5;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [4:0]             imm4to0;
		logic [6:0]             opcode;
	} sFmtS;

	typedef struct packed {
		logic                   imm12;
		logic [5:0]             imm10to5;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [3:0]             imm4to1;
		logic                   imm11;
		logic [6:0]             opcode;
	} bFmtS;

	typedef struct packed {
		logic [19:0]            imm31to12;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} uFmtS;

	typedef struct packed {
		logic                   imm20;
		logic [9:0]             imm10to1;
		logic                   imm11;
		logic [7:0]             imm19to12;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} jFmtS;

	typedef union packed {
		rFmtS rFmt;
		iFmtS iFmt;
		sFmtS sFmt;
		bFmtS bFmt;
		uFmtS uFmt;
		jFmtS jFmt;
	} instrU;

	// ******************************
	// Control encodings
	// ******************************

	typedef enum logic [3:0] {Add, Sub, Sll, Slt, Sltu, Xor, Srl, Sra, Or, And, PassB} aluOp;
	typedef enum logic [1:0] {FromRs1, FromPc, FromZero} opASel;
	typedef enum logic {FromRs2, FromImm} opBSel;
	typedef enum logic [1:0] {WbAlu, WbPcPlus4, WbMem} wbSel;
	typedef enum logic [1:0] {PcNext, PcBranch, PcJal, PcJalr} pcSel;

	typedef struct packed {
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       pcPlus4;
		logic [`XLEN-1:0]       rs1Val;
		logic [`XLEN-1:0]       rs2Val;
		logic [`XLEN-1:0]       imm;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rs1Addr;
		logic [`REG_ADDR_W-1:0] rs2Addr;
		logic [`REG_ADDR_W-1:0] rd;
		aluOp                   aluCtl;
		opASel                  opA;
		opBSel                  opB;
		wbSel                   wb;
		pcSel                   pcKind;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
	} decodeBundle; // All zero is a bubble

	typedef struct packed {
		logic [`XLEN-1:0]       writeData;
		logic [`XLEN-1:0]       memAddr;
		logic [`XLEN-1:0]       storeData;
		logic [`REG_ADDR_W-1:0] rd;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
		logic                   redirect;
		logic [`XLEN-1:0]       target;
	} execResult;

endpackage

// ==== logic/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ******************************
// Core widths
// ******************************

`define XLEN       32 // Operand, immediate, pc and result width
`define REG_ADDR_W 5  // Register address width

`endif
